//--- rtl/mem_defines.svh
// memory subsystem sizing
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// collections per ram group
// same count for single-port, simple dual-port and true dual-port groups
`define MEM_COLLECTIONS 2

// banks inside one collection
`define MEM_BANKS 4

// cells per bank
// small on purpose, keeps the reference model cheap
`define MEM_DEPTH 16

// bits per cell
// 10-bit fixed point weights and biases
`define MEM_WIDTH 10

`endif

//--- rtl/mem_pkg.sv
// memory subsystem types
`default_nettype none
`include "mem_defines.svh"

package mem_pkg;

	// total banks in one group, all collections flattened
	localparam int mem_banks_total = `MEM_COLLECTIONS * `MEM_BANKS;

	// address bits for a given depth, never below one bit
	function automatic int addr_bits(input int depth);
		return (depth > 1) ? $clog2(depth) : 1;
	endfunction

	typedef logic [`MEM_WIDTH-1:0] mem_cell_t;                 // one cell
	typedef logic [addr_bits(`MEM_DEPTH)-1:0] mem_addr_t;      // one bank address

	// flat vectors, entry i is bank (collection * MEM_BANKS + bank)
	typedef logic [mem_banks_total-1:0] mem_we_vec_t;          // one enable per bank
	typedef mem_addr_t [mem_banks_total-1:0] mem_addr_vec_t;
	typedef mem_cell_t [mem_banks_total-1:0] mem_cell_vec_t;

endpackage

`default_nettype wire

//--- rtl/sp_ram.sv
// single-port read-first ram
`default_nettype none

module sp_ram
	import mem_pkg::*;
#(
	parameter int depth = 16,                         // no. of cells
	parameter int width = 10,                         // bits per cell
	localparam int addrsize = addr_bits(depth)
)(
	input  wire logic                clk,
	input  wire logic                reset_i,
	input  wire logic                we_i,     // write enable, level
	input  wire logic [addrsize-1:0] addr_i,
	input  wire logic [width-1:0]    wdata_i,
	output      logic [width-1:0]    rdata_o   // registered, one cycle
);

	logic [width-1:0] mem [depth];

	// power-up contents all zero, no init file
	initial
	begin
		for (int i = 0; i < depth; i++)
			mem[i] = '0;
	end

	// write port, not touched by reset
	always_ff @(posedge clk)
	begin
		if (we_i)
			mem[addr_i] <= wdata_i;
	end

	// read port
	// nonblocking, so this sees the cell before this edge's write
	always_ff @(posedge clk)
	begin
		if (reset_i)
			rdata_o <= '0;          // clears output reg only
		else
			rdata_o <= mem[addr_i]; // read-first
	end

endmodule

`default_nettype wire

//--- rtl/sdp_ram.sv
// simple dual-port ram
`default_nettype none

module sdp_ram
	import mem_pkg::*;
#(
	parameter int depth = 16,
	parameter int width = 10,
	localparam int addrsize = addr_bits(depth)
)(
	input  wire logic                clk,
	input  wire logic                reset_i,
	input  wire logic                we_a_i,    // port a writes only
	input  wire logic [addrsize-1:0] addr_a_i,
	input  wire logic [width-1:0]    wdata_a_i,
	input  wire logic [addrsize-1:0] addr_b_i,  // port b reads every cycle
	output      logic [width-1:0]    rdata_b_o
);

	logic [width-1:0] mem [depth];   // weights / biases

	initial
	begin
		for (int i = 0; i < depth; i++)
			mem[i] = '0;           // zero at time zero
	end

	// port a, write only
	always_ff @(posedge clk)
	begin
		if (we_a_i)
			mem[addr_a_i] <= wdata_a_i;
	end

	// port b, read only
	// a same-address write on a returns the old cell here
	always_ff @(posedge clk)
	begin
		if (reset_i)
			rdata_b_o <= '0;
		else
			rdata_b_o <= mem[addr_b_i];
	end

endmodule

`default_nettype wire

//--- rtl/tdp_ram.sv
// true dual-port read-first ram
`default_nettype none

module tdp_ram
	import mem_pkg::*;
#(
	parameter int depth = 16,
	parameter int width = 10,
	localparam int addrsize = addr_bits(depth)
)(
	input  wire logic                clk,
	input  wire logic                reset_i,

	// port a
	input  wire logic                we_a_i,
	input  wire logic [addrsize-1:0] addr_a_i,
	input  wire logic [width-1:0]    wdata_a_i,
	output      logic [width-1:0]    rdata_a_o,

	// port b, mirror of a
	input  wire logic                we_b_i,
	input  wire logic [addrsize-1:0] addr_b_i,
	input  wire logic [width-1:0]    wdata_b_i,
	output      logic [width-1:0]    rdata_b_o
);

	logic [width-1:0] mem [depth];

	initial
	begin
		for (int i = 0; i < depth; i++)
			mem[i] = '0;
	end

	// both write ports in one process on the shared array
	// same address on both in one cycle is undefined, b lands last here
	always_ff @(posedge clk)
	begin
		if (we_a_i)
			mem[addr_a_i] <= wdata_a_i;
		if (we_b_i)
			mem[addr_b_i] <= wdata_b_i;
	end

	// port a read, pre-edge contents
	always_ff @(posedge clk)
	begin
		if (reset_i)
			rdata_a_o <= '0;
		else
			rdata_a_o <= mem[addr_a_i];
	end

	// port b read
	// a write on the other port at this address still shows old data
	always_ff @(posedge clk)
	begin
		if (reset_i)
			rdata_b_o <= '0;
		else
			rdata_b_o <= mem[addr_b_i];
	end

endmodule

`default_nettype wire

//--- rtl/mem_subsystem.sv
// accelerator memory subsystem top
`default_nettype none
`include "mem_defines.svh"

module mem_subsystem
	import mem_pkg::*;
(
	input  wire logic          clk,
	input  wire logic          reset_i,       // sync, clears read regs only

	// single-port group
	input  wire mem_we_vec_t   sp_we_i,
	input  wire mem_addr_vec_t sp_addr_i,
	input  wire mem_cell_vec_t sp_wdata_i,
	output      mem_cell_vec_t sp_rdata_o,

	// simple dual-port group, weights and biases
	input  wire mem_we_vec_t   sdp_we_a_i,    // write side
	input  wire mem_addr_vec_t sdp_addr_a_i,
	input  wire mem_cell_vec_t sdp_wdata_a_i,
	input  wire mem_addr_vec_t sdp_addr_b_i,  // read side
	output      mem_cell_vec_t sdp_rdata_b_o,

	// true dual-port group
	input  wire mem_we_vec_t   tdp_we_a_i,
	input  wire mem_addr_vec_t tdp_addr_a_i,
	input  wire mem_cell_vec_t tdp_wdata_a_i,
	output      mem_cell_vec_t tdp_rdata_a_o,
	input  wire mem_we_vec_t   tdp_we_b_i,
	input  wire mem_addr_vec_t tdp_addr_b_i,
	input  wire mem_cell_vec_t tdp_wdata_b_i,
	output      mem_cell_vec_t tdp_rdata_b_o
);

	// flat bank index = collection * MEM_BANKS + bank
	// every vector entry i belongs to that one bank

	genvar gv_c, gv_b;

	// single-port banks
	generate
		for (gv_c = 0; gv_c < `MEM_COLLECTIONS; gv_c++)
		begin : sp_coll
			for (gv_b = 0; gv_b < `MEM_BANKS; gv_b++)
			begin : sp_bank
				localparam int idx = gv_c * `MEM_BANKS + gv_b;

				sp_ram #(
					.depth(`MEM_DEPTH),
					.width(`MEM_WIDTH)
				) u_sp_ram (
					.clk,
					.reset_i,
					.we_i    (sp_we_i[idx]),
					.addr_i  (sp_addr_i[idx]),
					.wdata_i (sp_wdata_i[idx]),
					.rdata_o (sp_rdata_o[idx])   // one cycle after addr
				);
			end
		end
	endgenerate

	// simple dual-port banks
	// a writes, b reads, both on clk
	generate
		for (gv_c = 0; gv_c < `MEM_COLLECTIONS; gv_c++)
		begin : sdp_coll
			for (gv_b = 0; gv_b < `MEM_BANKS; gv_b++)
			begin : sdp_bank
				localparam int idx = gv_c * `MEM_BANKS + gv_b;

				sdp_ram #(
					.depth(`MEM_DEPTH),
					.width(`MEM_WIDTH)
				) u_sdp_ram (
					.clk,
					.reset_i,
					.we_a_i    (sdp_we_a_i[idx]),
					.addr_a_i  (sdp_addr_a_i[idx]),
					.wdata_a_i (sdp_wdata_a_i[idx]),
					.addr_b_i  (sdp_addr_b_i[idx]),
					.rdata_b_o (sdp_rdata_b_o[idx])
				);
			end
		end
	endgenerate

	// true dual-port banks
	// both ports read every cycle, either may write
	generate
		for (gv_c = 0; gv_c < `MEM_COLLECTIONS; gv_c++)
		begin : tdp_coll
			for (gv_b = 0; gv_b < `MEM_BANKS; gv_b++)
			begin : tdp_bank
				localparam int idx = gv_c * `MEM_BANKS + gv_b;

				tdp_ram #(
					.depth(`MEM_DEPTH),
					.width(`MEM_WIDTH)
				) u_tdp_ram (
					.clk,
					.reset_i,
					// port a
					.we_a_i    (tdp_we_a_i[idx]),
					.addr_a_i  (tdp_addr_a_i[idx]),
					.wdata_a_i (tdp_wdata_a_i[idx]),
					.rdata_a_o (tdp_rdata_a_o[idx]),
					// port b
					.we_b_i    (tdp_we_b_i[idx]),
					.addr_b_i  (tdp_addr_b_i[idx]),
					.wdata_b_i (tdp_wdata_b_i[idx]),
					.rdata_b_o (tdp_rdata_b_o[idx])
				);
			end
		end
	endgenerate

endmodule

`default_nettype wire

//--- verif/mem_tb_tasks.svh
// testbench stimulus and waits
`ifndef MEM_TB_TASKS_SVH
`define MEM_TB_TASKS_SVH

// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
endfunction

// n random bits, one lfsr step per bit
function automatic logic [31:0] take_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int k = 0; k < n; k++)
	begin
		lfsr_state = lfsr_next(lfsr_state);
		v = {v[30:0], lfsr_state[0]};
	end
	return v;
endfunction

task automatic next_cycle();
	@(posedge clk);
	#drive_dly;             // clear of the edge
endtask

// all write enables low, write data and sdp write address zeroed
// read addresses kept
task automatic idle_ports();
	sp_we    = '0;
	sdp_we_a = '0;
	tdp_we_a = '0;
	tdp_we_b = '0;
	sp_wdata    = '0;
	sdp_wdata_a = '0;
	sdp_addr_a  = '0;
	tdp_wdata_a = '0;
	tdp_wdata_b = '0;
endtask

// random read address on every read port
task automatic scatter_reads();
	for (int b = 0; b < n_banks; b++)
	begin
		sp_addr[b]    = mem_addr_t'(take_bits(addr_w));
		sdp_addr_b[b] = mem_addr_t'(take_bits(addr_w));
		tdp_addr_a[b] = mem_addr_t'(take_bits(addr_w));
		tdp_addr_b[b] = mem_addr_t'(take_bits(addr_w));
	end
endtask

// bounded wait until every read output is zero
task automatic wait_reads_cleared(input string phase);
	int n;
	n = 0;
	while ((sp_rdata | sdp_rdata_b | tdp_rdata_a | tdp_rdata_b) !== '0 && n < wait_limit)
	begin
		next_cycle();
		n++;
	end
	if ((sp_rdata | sdp_rdata_b | tdp_rdata_a | tdp_rdata_b) !== '0)
		fail_timeout(phase);
endtask

task automatic apply_reset(input int cycles, input string phase);
	idle_ports();
	reset = 1'b1;
	next_cycle();
	check_on = 1'b1;        // outputs defined from here on
	wait_reads_cleared(phase);
	for (int n = 1; n < cycles; n++)
		next_cycle();
	reset = 1'b0;
endtask

// every cell of every port, no writes
task automatic read_sweep();
	idle_ports();
	for (int a = 0; a < n_cells; a++)
	begin
		sp_addr    = {n_banks{mem_addr_t'(a)}};
		sdp_addr_b = {n_banks{mem_addr_t'(a)}};
		tdp_addr_a = {n_banks{mem_addr_t'(a)}};
		tdp_addr_b = {n_banks{mem_addr_t'(a)}};
		next_cycle();
	end
	next_cycle();           // last read lands
endtask

// write, overwrite (old value out), then plain read
task automatic sp_directed();
	mem_cell_t d;
	for (int b = 0; b < n_banks; b++)
	begin
		idle_ports();
		d = mem_cell_t'(take_bits(cell_w));
		sp_we[b]    = 1'b1;
		sp_addr[b]  = mem_addr_t'(take_bits(addr_w));
		sp_wdata[b] = d;
		next_cycle();
		sp_wdata[b] = ~d;
		next_cycle();
		sp_we[b] = 1'b0;    // read back ~d
		next_cycle();
	end
	idle_ports();
endtask

// write on a with b on the same cell, then b again
task automatic sdp_directed();
	mem_addr_t a;
	for (int b = 0; b < n_banks; b++)
	begin
		idle_ports();
		a = mem_addr_t'(take_bits(addr_w));
		sdp_we_a[b]    = 1'b1;
		sdp_addr_a[b]  = a;
		sdp_wdata_a[b] = mem_cell_t'(take_bits(cell_w));
		sdp_addr_b[b]  = a;  // collision, old value
		next_cycle();
		sdp_we_a[b] = 1'b0;
		next_cycle();
		next_cycle();
	end
	idle_ports();
endtask

task automatic tdp_random(input int cycles);
	for (int n = 0; n < cycles; n++)
	begin
		idle_ports();
		for (int b = 0; b < n_banks; b++)
		begin
			tdp_we_a[b]    = (take_bits(1) != 0);
			tdp_we_b[b]    = (take_bits(1) != 0);
			tdp_addr_a[b]  = mem_addr_t'(take_bits(addr_w));
			tdp_addr_b[b]  = mem_addr_t'(take_bits(addr_w));
			tdp_wdata_a[b] = mem_cell_t'(take_bits(cell_w));
			tdp_wdata_b[b] = mem_cell_t'(take_bits(cell_w));
			if (take_bits(2) == 0)
				tdp_addr_b[b] = tdp_addr_a[b];    // same-cell traffic
			if (tdp_we_a[b] && tdp_we_b[b] && tdp_addr_a[b] == tdp_addr_b[b])
				tdp_we_b[b] = 1'b0;               // no double write
		end
		next_cycle();
	end
	idle_ports();
endtask

// one enable bit over all groups per cycle
task automatic single_bank_random(input int cycles);
	int grp;
	int bank;
	for (int n = 0; n < cycles; n++)
	begin
		idle_ports();
		scatter_reads();
		grp  = int'(take_bits(2)) % 3;
		bank = int'(take_bits(bank_w)) % n_banks;
		case (grp)
		0:
		begin
			sp_we[bank]    = 1'b1;
			sp_wdata[bank] = mem_cell_t'(take_bits(cell_w));
		end
		1:
		begin
			sdp_we_a[bank]    = 1'b1;
			sdp_addr_a[bank]  = mem_addr_t'(take_bits(addr_w));
			sdp_wdata_a[bank] = mem_cell_t'(take_bits(cell_w));
		end
		default:
		begin
			if (take_bits(1) != 0)
			begin
				tdp_we_a[bank]    = 1'b1;
				tdp_wdata_a[bank] = mem_cell_t'(take_bits(cell_w));
			end
			else
			begin
				tdp_we_b[bank]    = 1'b1;
				tdp_wdata_b[bank] = mem_cell_t'(take_bits(cell_w));
			end
		end
		endcase
		next_cycle();
	end
	idle_ports();
endtask

`endif

//--- verif/mem_tb.sv
// memory subsystem testbench
`default_nettype none
`include "mem_defines.svh"

module mem_tb
	import mem_pkg::*;
();

	localparam int n_banks   = `MEM_COLLECTIONS * `MEM_BANKS;   // flat banks per group
	localparam int n_cells   = `MEM_DEPTH;
	localparam int addr_w    = $bits(mem_addr_t);
	localparam int cell_w    = $bits(mem_cell_t);
	localparam int bank_w    = (n_banks > 1) ? $clog2(n_banks) : 1;
	localparam int period    = 40;
	localparam int drive_dly = 5;     // inputs change this long after posedge
	localparam int wait_limit = 20;   // cycles any bounded wait may take

	logic clk = 1'b0;
	logic reset;
	logic check_on;                   // read checks live once outputs are defined
	logic [15:0] lfsr_state = 16'd35;

	// dut inputs
	mem_we_vec_t   sp_we;
	mem_addr_vec_t sp_addr;
	mem_cell_vec_t sp_wdata;
	mem_we_vec_t   sdp_we_a;
	mem_addr_vec_t sdp_addr_a;
	mem_cell_vec_t sdp_wdata_a;
	mem_addr_vec_t sdp_addr_b;
	mem_we_vec_t   tdp_we_a;
	mem_we_vec_t   tdp_we_b;
	mem_addr_vec_t tdp_addr_a;
	mem_addr_vec_t tdp_addr_b;
	mem_cell_vec_t tdp_wdata_a;
	mem_cell_vec_t tdp_wdata_b;

	// dut outputs
	mem_cell_vec_t sp_rdata;
	mem_cell_vec_t sdp_rdata_b;
	mem_cell_vec_t tdp_rdata_a;
	mem_cell_vec_t tdp_rdata_b;

	// reference contents and expected read pipeline
	mem_cell_t sp_ref  [n_banks][n_cells];
	mem_cell_t sdp_ref [n_banks][n_cells];
	mem_cell_t tdp_ref [n_banks][n_cells];
	mem_cell_t sp_exp    [n_banks];
	mem_cell_t sdp_exp   [n_banks];
	mem_cell_t tdp_exp_a [n_banks];
	mem_cell_t tdp_exp_b [n_banks];

	always #(period / 2) clk = ~clk;

	mem_subsystem UUT (
		.clk           (clk),
		.reset_i       (reset),
		.sp_we_i       (sp_we),
		.sp_addr_i     (sp_addr),
		.sp_wdata_i    (sp_wdata),
		.sp_rdata_o    (sp_rdata),
		.sdp_we_a_i    (sdp_we_a),
		.sdp_addr_a_i  (sdp_addr_a),
		.sdp_wdata_a_i (sdp_wdata_a),
		.sdp_addr_b_i  (sdp_addr_b),
		.sdp_rdata_b_o (sdp_rdata_b),
		.tdp_we_a_i    (tdp_we_a),
		.tdp_addr_a_i  (tdp_addr_a),
		.tdp_wdata_a_i (tdp_wdata_a),
		.tdp_rdata_a_o (tdp_rdata_a),
		.tdp_we_b_i    (tdp_we_b),
		.tdp_addr_b_i  (tdp_addr_b),
		.tdp_wdata_b_i (tdp_wdata_b),
		.tdp_rdata_b_o (tdp_rdata_b)
	);

	initial
	begin
		for (int b = 0; b < n_banks; b++)
		begin
			for (int a = 0; a < n_cells; a++)
			begin
				sp_ref[b][a]  = '0;   // power-up contents
				sdp_ref[b][a] = '0;
				tdp_ref[b][a] = '0;
			end
		end
	end

	// read-first model, expected data lands one edge after the address
	always @(posedge clk)
	begin
		for (int i = 0; i < n_banks; i++)
		begin
			sp_exp[i]    <= reset ? '0 : sp_ref[i][sp_addr[i]];
			sdp_exp[i]   <= reset ? '0 : sdp_ref[i][sdp_addr_b[i]];
			tdp_exp_a[i] <= reset ? '0 : tdp_ref[i][tdp_addr_a[i]];
			tdp_exp_b[i] <= reset ? '0 : tdp_ref[i][tdp_addr_b[i]];
			if (sp_we[i])
				sp_ref[i][sp_addr[i]] <= sp_wdata[i];          // kept through reset
			if (sdp_we_a[i])
				sdp_ref[i][sdp_addr_a[i]] <= sdp_wdata_a[i];
			if (tdp_we_a[i])
				tdp_ref[i][tdp_addr_a[i]] <= tdp_wdata_a[i];
			if (tdp_we_b[i])
				tdp_ref[i][tdp_addr_b[i]] <= tdp_wdata_b[i];   // never same cell as a
		end
	end

	task automatic report_mismatch(input string grp, input int bank, input string port,
			input mem_cell_t got, input mem_cell_t exp);
		$display("Mismatch at time %0t: %s bank %0d port %s read %h, expected %h",
			$time, grp, bank, port, got, exp);
		$display("TESTBENCH FAILED");
		$fatal(1, "read data check failed");
	endtask

	task automatic fail_timeout(input string phase);
		$display("Timeout: the %s phase did not finish within %0d cycles", phase, wait_limit);
		$display("TESTBENCH FAILED");
		$fatal(1, "bounded wait expired");
	endtask

	// every read port against the model, every edge
	genvar gi;
	generate
		for (gi = 0; gi < n_banks; gi++)
		begin : chk
			sp_rd: assert property (@(posedge clk) disable iff (!check_on)
				sp_rdata[gi] == sp_exp[gi])
			else
				report_mismatch("single-port", gi, "rd", $sampled(sp_rdata[gi]),
					$sampled(sp_exp[gi]));
			sdp_rd: assert property (@(posedge clk) disable iff (!check_on)
				sdp_rdata_b[gi] == sdp_exp[gi])
			else
				report_mismatch("simple dual-port", gi, "b", $sampled(sdp_rdata_b[gi]),
					$sampled(sdp_exp[gi]));
			tdp_rd_a: assert property (@(posedge clk) disable iff (!check_on)
				tdp_rdata_a[gi] == tdp_exp_a[gi])
			else
				report_mismatch("true dual-port", gi, "a", $sampled(tdp_rdata_a[gi]),
					$sampled(tdp_exp_a[gi]));
			tdp_rd_b: assert property (@(posedge clk) disable iff (!check_on)
				tdp_rdata_b[gi] == tdp_exp_b[gi])
			else
				report_mismatch("true dual-port", gi, "b", $sampled(tdp_rdata_b[gi]),
					$sampled(tdp_exp_b[gi]));
		end
	endgenerate

	`include "mem_tb_tasks.svh"

	initial
	begin
		reset    = 1'b0;
		check_on = 1'b0;
		idle_ports();
		sp_addr    = '0;
		sdp_addr_b = '0;
		tdp_addr_a = '0;
		tdp_addr_b = '0;

		apply_reset(3, "power-up reset");
		read_sweep();                    // untouched cells read zero
		sp_directed();
		sdp_directed();
		tdp_random(200);
		single_bank_random(300);         // one enable at a time
		apply_reset(3, "mid-run reset");
		read_sweep();                    // contents survived the reset
		next_cycle();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
+incdir+verif
rtl/mem_pkg.sv
rtl/sp_ram.sv
rtl/sdp_ram.sv
rtl/tdp_ram.sv
rtl/mem_subsystem.sv
verif/mem_tb.sv
